// File: flist.f
+incdir+verilog
verilog/CoreTypes.sv
verilog/PipelineTypes.sv
verilog/RegisterFile.sv
verilog/StallController.sv
verilog/StageIF.sv
verilog/StageID.sv
verilog/StageEX.sv
verilog/StageMEM.sv
verilog/ProcessorPP.sv
tb/ProcessorChecker.sv
tb/ProcessorTb.sv

// File: tb/ProcessorChecker.sv
`timescale 1ns/1ps

module ProcessorChecker (
    input  logic                     i_clock,     // Clock
    input  logic                     i_reset,     // Reset
    input  PipelineTypes::DataBusReq i_dataReq,   // DUT data request
    input  logic                     i_dataBusy,  // Back-pressure seen by the DUT
    output int                       o_checked,   // Stores compared so far
    output int                       o_passed,
    output int                       o_failed,
    output int                       o_errors);   // Protocol and extra-store errors

    string                    expName [64];      // Expected stores, program order
    CoreTypes::Data           expAddr [64];
    CoreTypes::Data           expData [64];
    int                       expCount = 0;
    int                       checked  = 0;
    int                       passed   = 0;
    int                       failed   = 0;
    int                       errors   = 0;
    PipelineTypes::DataBusReq lastReq;
    logic                     lastStalled = 1'b0;  // Pending and busy last cycle

    assign o_checked = checked;
    assign o_passed  = passed;
    assign o_failed  = failed;
    assign o_errors  = errors;

    task automatic addExpected(input string name, input CoreTypes::Data addr,
                               input CoreTypes::Data data);
        expName[expCount] = name;
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expCount++;
    endtask

    task automatic reportMissing();
        for (int i = checked; i < expCount; i++)
            $display("Store for test %s never appeared on the data bus", expName[i]);
    endtask

    // ------------------------------
    // Bus monitor
    // ------------------------------

    always @(posedge i_clock) begin
        if (i_reset) begin
            if (i_dataReq.rd === 1'b1 || i_dataReq.wr === 1'b1) begin
                $display("Data request made while reset is high at %0t ns", $time);
                errors++;
            end
            lastStalled <= 1'b0;
        end
        else begin
            if (lastStalled && i_dataReq !== lastReq) begin   // Must hold while busy
                $display("Data request changed while the bus was busy at %0t ns", $time);
                errors++;
            end
            if (i_dataReq.wr === 1'b1 && i_dataBusy === 1'b0) begin  // Store completes
                if (checked >= expCount) begin
                    $display("Unexpected extra store to %h with data %h at %0t ns",
                             i_dataReq.addr, i_dataReq.wrData, $time);
                    errors++;
                end
                else begin
                    if (i_dataReq.addr === expAddr[checked] &&
                        i_dataReq.wrData === expData[checked]) begin
                        $display("Test %s passed: addr %h data %h", expName[checked],
                                 i_dataReq.addr, i_dataReq.wrData);
                        passed++;
                    end
                    else begin
                        $display("** Error %s: expected addr %h data %h, actual addr %h data %h",
                                 expName[checked], expAddr[checked], expData[checked],
                                 i_dataReq.addr, i_dataReq.wrData);
                        failed++;
                    end
                    checked++;
                end
            end
            lastStalled <= (i_dataReq.rd === 1'b1 || i_dataReq.wr === 1'b1) &&
                           i_dataBusy === 1'b1;
            lastReq     <= i_dataReq;
        end
    end

endmodule

// File: tb/ProcessorTb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module ProcessorTb;

    localparam int clockPeriod = 40;              // ns
    localparam int memWords    = 256;             // Both memory models

    logic                     clock;
    logic                     reset;
    CoreTypes::InstAddr       instAddr;
    CoreTypes::Inst           inst;
    PipelineTypes::DataBusReq dataReq;
    CoreTypes::Data           dataRdData;
    logic                     dataBusy;
    int                       checked;
    int                       passed;
    int                       failed;
    int                       errors;

    CoreTypes::Inst imem [memWords];
    CoreTypes::Data dmem [memWords];
    int             seed        = 1024;           // Busy pattern
    int             progWords   = 0;
    int             numExpected = 0;
    logic           loaded      = 1'b0;

    ProcessorPP u_dut (
        .i_clock      (clock),
        .i_reset      (reset),
        .o_instAddr   (instAddr),
        .i_inst       (inst),
        .o_dataReq    (dataReq),
        .i_dataRdData (dataRdData),
        .i_dataBusy   (dataBusy));

    ProcessorChecker u_checker (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_dataReq  (dataReq),
        .i_dataBusy (dataBusy),
        .o_checked  (checked),
        .o_passed   (passed),
        .o_failed   (failed),
        .o_errors   (errors));

    // ------------------------------
    // Memory models
    // ------------------------------

    assign inst       = (instAddr < memWords * 4) ? imem[instAddr[9:2]] : `RV_NOP;
    assign dataRdData = dmem[dataReq.addr[9:2]];  // Combinational read

    always @(posedge clock) begin
        if (dataReq.wr === 1'b1 && dataBusy === 1'b0)
            dmem[dataReq.addr[9:2]] <= dataReq.wrData;
    end

    // About one pending cycle in three is busy
    always @(negedge clock) begin
        if (!reset && (dataReq.rd === 1'b1 || dataReq.wr === 1'b1))
            dataBusy <= ($unsigned($random(seed)) % 3) == 0;
        else
            dataBusy <= 1'b0;
    end

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic loadTestData();
        int             fd;
        int             n;
        string          line;
        string          name;
        CoreTypes::Data addr;
        CoreTypes::Data value;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = `RV_NOP;
            dmem[i] = 32'hA5A5_0000 ^ (i * 4);    // Tagged with the byte address
        end
        fd = $fopen("tb/testdata.txt", "r");
        if (fd == 0)
            $display("Cannot open tb/testdata.txt");
        else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1) begin
                    case (line.getc(0))
                        "P": if ($sscanf(line, "P %h", value) == 1) begin
                            imem[progWords] = value;
                            progWords++;
                        end
                        "D": if ($sscanf(line, "D %h %h", addr, value) == 2)
                            dmem[addr[9:2]] = value;
                        "E": if ($sscanf(line, "E %s %h %h", name, addr, value) == 3) begin
                            u_checker.addExpected(name, addr, value);
                            numExpected++;
                        end
                        default: ;                // Comment line
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic printCounts();
        $display("Summary: %0d passed, %0d failed, %0d other errors, %0d of %0d stores seen",
                 passed, failed, errors, checked, numExpected);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        reset    = 1'b1;
        dataBusy = 1'b0;
        loadTestData();
        if (numExpected == 0) begin
            $display("No expected stores were loaded from the data file");
            $display("Test failed");
            $finish;
        end
        else begin
            loaded = 1'b1;
            repeat (4) @(negedge clock);
            reset = 1'b0;
            wait (checked == numExpected);
            repeat (20) @(negedge clock);         // Room for any extra store
            printCounts();
            if (failed == 0 && errors == 0 && checked == numExpected)
                $display("Test completed successfully");
            else
                $display("Test failed");
            $finish;
        end
    end

    // Watchdog sized from the program length
    initial begin
        wait (loaded);
        #((progWords + 20) * 4 * clockPeriod);
        $display("Timeout: the run did not finish in time");
        u_checker.reportMissing();
        printCounts();
        $display("Test failed");
        $finish;
    end

endmodule

// File: tb/testdata.txt
# P word: program word in fetch order | D addr value: data preload
# E name addr value: expected store in program order (hex)
P 00500093
P 00708113
P 002081B3
P 10302023
P 40118233
P 003242B3
P 10502223
P 40100333
P 001323B3
P 0043E433
P 10802423
P 1F412483
P 00648533
P 10A12023
P 00908013
P 10002823
P 004575B3
P 00058633
P 10C02A23
P 20402683
P 10D02C23
D 00000200 00000064
D 00000204 CAFEF00D
E add_fwd 00000100 00000011
E sub_xor 00000104 0000001D
E slt_or 00000108 0000000D
E load_use 0000010C 0000005F
E x0_store 00000110 00000000
E and_x0 00000114 0000000C
E load_store 00000118 CAFEF00D

// File: verilog/CoreTypes.sv
`include "rv_macros.svh"

package CoreTypes;

    typedef logic [`RV_XLEN-1:0]              Data;      // Data word
    typedef logic [`RV_XLEN-1:0]              InstAddr;  // Instruction address
    typedef logic [`RV_XLEN-1:0]              Inst;      // Instruction word
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] RegAddr;   // Register index

    // ------------------------------
    // Instruction fields
    // ------------------------------

    typedef enum logic [6:0] {
        OP     = 7'b0110011,            // Register-register ALU
        OP_IMM = 7'b0010011,            // Register-immediate ALU
        LOAD   = 7'b0000011,            // LW
        STORE  = 7'b0100011             // SW
    } Opcode;

    typedef enum logic [2:0] {
        ALU_ADD,                        // Also load/store address
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT                         // Signed compare
    } AluOp;

endpackage

// File: verilog/PipelineTypes.sv
package PipelineTypes;

    typedef struct packed {
        logic              isValid;
        CoreTypes::Data    dataA;       // Forwarded rs1
        CoreTypes::Data    dataB;       // Forwarded rs2, store data
        CoreTypes::Data    immediate;   // I or S immediate
        CoreTypes::RegAddr regWrAddr;
        logic              regWrEnable;
        logic              memRdEnable;
        logic              memWrEnable;
        CoreTypes::AluOp   aluOp;
        logic              useImm;      // Operand B from immediate
    } IdExReg;

    typedef struct packed {
        logic              isValid;
        CoreTypes::Data    result;      // ALU result or memory address
        CoreTypes::Data    storeData;
        CoreTypes::RegAddr regWrAddr;
        logic              regWrEnable;
        logic              memRdEnable;
        logic              memWrEnable;
    } ExMemReg;

    typedef struct packed {
        logic              isValid;
        CoreTypes::RegAddr regWrAddr;
        logic              regWrEnable;
        CoreTypes::Data    regWrData;
    } MemWbReg;

    typedef struct packed {
        CoreTypes::RegAddr rs1;
        logic              rs1Used;
        CoreTypes::RegAddr rs2;
        logic              rs2Used;
    } SrcRegs;

    typedef struct packed {
        logic ifIdStall;
        logic idExStall;
        logic idExFlush;                // Bubble into EX
        logic exMemStall;
        logic memWbFlush;               // Bubble into WB
    } StallCtrl;

    typedef struct packed {
        CoreTypes::Data addr;
        CoreTypes::Data wrData;
        logic           rd;
        logic           wr;
    } DataBusReq;

endpackage

// File: verilog/ProcessorPP.sv
`timescale 1ns/1ps

module ProcessorPP (
    input  logic                     i_clock,       // Clock
    input  logic                     i_reset,       // Reset
    output CoreTypes::InstAddr       o_instAddr,    // Instruction bus address
    input  CoreTypes::Inst           i_inst,        // Instruction, same cycle
    output PipelineTypes::DataBusReq o_dataReq,     // Data bus request
    input  CoreTypes::Data           i_dataRdData,  // Load data
    input  logic                     i_dataBusy);   // Data bus back-pressure

    PipelineTypes::StallCtrl ctrl;
    CoreTypes::InstAddr      ifIdPc;
    CoreTypes::Inst          ifIdInst;
    logic                    ifIdIsValid;
    CoreTypes::RegAddr       rdAddrA;
    CoreTypes::RegAddr       rdAddrB;
    CoreTypes::Data          rdDataA;
    CoreTypes::Data          rdDataB;
    PipelineTypes::SrcRegs   srcRegs;
    PipelineTypes::IdExReg   idEx;
    CoreTypes::Data          exResult;
    PipelineTypes::ExMemReg  exMem;
    CoreTypes::Data          memWrData;
    PipelineTypes::MemWbReg  memWb;
    logic                    busyHazard;

    // ------------------------------
    // Control
    // ------------------------------

    StallController stallCtrl (
        .i_srcRegs    (srcRegs),
        .i_idEx       (idEx),
        .i_busyHazard (busyHazard),
        .o_stallCtrl  (ctrl));

    RegisterFile regs (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rdAddrA (rdAddrA),
        .i_rdAddrB (rdAddrB),
        .o_rdDataA (rdDataA),
        .o_rdDataB (rdDataB),
        .i_memWb   (memWb));                  // WB port

    // ------------------------------
    // Stages
    // ------------------------------

    StageIF stageIF (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_stallCtrl (ctrl),
        .o_instAddr  (o_instAddr),
        .i_inst      (i_inst),
        .o_pc        (ifIdPc),
        .o_inst      (ifIdInst),
        .o_isValid   (ifIdIsValid));

    StageID stageID (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_stallCtrl (ctrl),
        .i_inst      (ifIdInst),
        .i_pc        (ifIdPc),
        .i_isValid   (ifIdIsValid),
        .i_exResult  (exResult),              // Forward from EX
        .i_exMem     (exMem),
        .i_memWrData (memWrData),             // Forward from MEM
        .i_memWb     (memWb),                 // Forward from WB
        .i_rdDataA   (rdDataA),
        .i_rdDataB   (rdDataB),
        .o_rdAddrA   (rdAddrA),
        .o_rdAddrB   (rdAddrB),
        .o_srcRegs   (srcRegs),
        .o_idEx      (idEx));

    StageEX stageEX (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_stallCtrl (ctrl),
        .i_idEx      (idEx),
        .o_result    (exResult),
        .o_exMem     (exMem));

    StageMEM stageMEM (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_stallCtrl  (ctrl),
        .i_exMem      (exMem),
        .o_dataReq    (o_dataReq),
        .i_dataRdData (i_dataRdData),
        .i_dataBusy   (i_dataBusy),
        .o_busyHazard (busyHazard),
        .o_wrData     (memWrData),
        .o_memWb      (memWb));

endmodule

// File: verilog/RegisterFile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module RegisterFile (
    input  logic                   i_clock,     // Clock
    input  logic                   i_reset,     // Reset
    input  CoreTypes::RegAddr      i_rdAddrA,   // Read port A address
    input  CoreTypes::RegAddr      i_rdAddrB,   // Read port B address
    output CoreTypes::Data         o_rdDataA,   // Read port A data
    output CoreTypes::Data         o_rdDataB,   // Read port B data
    input  PipelineTypes::MemWbReg i_memWb);    // Write-back port

    CoreTypes::Data regs [`RV_REG_COUNT];       // x0 never written

    logic wrEnable;

    assign wrEnable = i_memWb.isValid && i_memWb.regWrEnable &&
                      (i_memWb.regWrAddr != '0);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wrEnable)
            regs[i_memWb.regWrAddr] <= i_memWb.regWrData;
    end

    // Async reads, x0 forced to zero
    assign o_rdDataA = (i_rdAddrA == '0) ? '0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 : regs[i_rdAddrB];

endmodule

// File: verilog/StageEX.sv
`timescale 1ns/1ps

module StageEX (
    input  logic                    i_clock,      // Clock
    input  logic                    i_reset,      // Reset
    input  PipelineTypes::StallCtrl i_stallCtrl,  // Stall controls
    input  PipelineTypes::IdExReg   i_idEx,       // ID/EX register
    output CoreTypes::Data          o_result,     // ALU result, also forwarded
    output PipelineTypes::ExMemReg  o_exMem);     // EX/MEM register

    CoreTypes::Data opA;
    CoreTypes::Data opB;

    // ------------------------------
    // ALU
    // ------------------------------

    assign opA = i_idEx.dataA;
    assign opB = i_idEx.useImm ? i_idEx.immediate : i_idEx.dataB;

    always_comb begin
        case (i_idEx.aluOp)
            CoreTypes::ALU_SUB: o_result = opA - opB;
            CoreTypes::ALU_AND: o_result = opA & opB;
            CoreTypes::ALU_OR:  o_result = opA | opB;
            CoreTypes::ALU_XOR: o_result = opA ^ opB;
            CoreTypes::ALU_SLT: o_result = CoreTypes::Data'($signed(opA) < $signed(opB));
            default:            o_result = opA + opB;   // ADD, LW/SW address
        endcase
    end

    // ------------------------------
    // EX/MEM register
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_exMem.isValid     <= 1'b0;
            o_exMem.regWrEnable <= 1'b0;
            o_exMem.memRdEnable <= 1'b0;
            o_exMem.memWrEnable <= 1'b0;
        end
        else if (!i_stallCtrl.exMemStall) begin   // Held while the bus is busy
            o_exMem.isValid     <= i_idEx.isValid;
            o_exMem.result      <= o_result;
            o_exMem.storeData   <= i_idEx.dataB;
            o_exMem.regWrAddr   <= i_idEx.regWrAddr;
            o_exMem.regWrEnable <= i_idEx.regWrEnable;
            o_exMem.memRdEnable <= i_idEx.memRdEnable;
            o_exMem.memWrEnable <= i_idEx.memWrEnable;
        end
    end

endmodule

// File: verilog/StageID.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module StageID (
    input  logic                    i_clock,      // Clock
    input  logic                    i_reset,      // Reset
    input  PipelineTypes::StallCtrl i_stallCtrl,  // Stall controls
    input  CoreTypes::Inst          i_inst,       // IF/ID instruction
    input  CoreTypes::InstAddr      i_pc,         // IF/ID address
    input  logic                    i_isValid,    // IF/ID valid
    input  CoreTypes::Data          i_exResult,   // ALU result in EX
    input  PipelineTypes::ExMemReg  i_exMem,      // Instruction in MEM
    input  CoreTypes::Data          i_memWrData,  // Write-back value in MEM
    input  PipelineTypes::MemWbReg  i_memWb,      // Instruction in WB
    input  CoreTypes::Data          i_rdDataA,    // Register file port A
    input  CoreTypes::Data          i_rdDataB,    // Register file port B
    output CoreTypes::RegAddr       o_rdAddrA,
    output CoreTypes::RegAddr       o_rdAddrB,
    output PipelineTypes::SrcRegs   o_srcRegs,    // To hazard detection
    output PipelineTypes::IdExReg   o_idEx);      // ID/EX register

    logic                  known;                 // Opcode in the subset
    CoreTypes::Inst        inst;
    PipelineTypes::IdExReg idExNext;

    function automatic CoreTypes::AluOp aluDecode(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? CoreTypes::ALU_SUB : CoreTypes::ALU_ADD;
            3'b010:  return CoreTypes::ALU_SLT;
            3'b100:  return CoreTypes::ALU_XOR;
            3'b110:  return CoreTypes::ALU_OR;
            3'b111:  return CoreTypes::ALU_AND;
            default: return CoreTypes::ALU_ADD;
        endcase
    endfunction

    // Youngest producer wins and x0 is never forwarded
    function automatic CoreTypes::Data forward(
        input CoreTypes::RegAddr addr,
        input CoreTypes::Data    rfData);
        if (addr == '0)
            return rfData;
        else if (o_idEx.isValid && o_idEx.regWrEnable && o_idEx.regWrAddr == addr)
            return i_exResult;                    // From EX
        else if (i_exMem.isValid && i_exMem.regWrEnable && i_exMem.regWrAddr == addr)
            return i_memWrData;                   // From MEM
        else if (i_memWb.isValid && i_memWb.regWrEnable && i_memWb.regWrAddr == addr)
            return i_memWb.regWrData;             // From WB
        else
            return rfData;
    endfunction

    // ------------------------------
    // Decode
    // ------------------------------

    assign inst      = i_isValid ? i_inst : `RV_NOP;   // Empty slot decodes as NOP
    assign o_rdAddrA = inst[19:15];
    assign o_rdAddrB = inst[24:20];

    always_comb begin
        known                = 1'b1;
        o_srcRegs.rs1        = inst[19:15];
        o_srcRegs.rs2        = inst[24:20];
        o_srcRegs.rs1Used    = 1'b1;
        o_srcRegs.rs2Used    = 1'b0;
        idExNext.regWrAddr   = inst[11:7];
        idExNext.immediate   = {{20{inst[31]}}, inst[31:20]};            // I-type
        idExNext.aluOp       = CoreTypes::ALU_ADD;
        idExNext.useImm      = 1'b1;
        idExNext.regWrEnable = 1'b0;
        idExNext.memRdEnable = 1'b0;
        idExNext.memWrEnable = 1'b0;
        case (inst[6:0])
            CoreTypes::OP: begin
                idExNext.useImm      = 1'b0;
                idExNext.regWrEnable = 1'b1;
                idExNext.aluOp       = aluDecode(inst[14:12], inst[30]);
                o_srcRegs.rs2Used    = 1'b1;
            end
            CoreTypes::OP_IMM: begin
                idExNext.regWrEnable = 1'b1;
                idExNext.aluOp       = aluDecode(inst[14:12], 1'b0); // No SUBI
            end
            CoreTypes::LOAD: begin
                idExNext.regWrEnable = 1'b1;
                idExNext.memRdEnable = 1'b1;
            end
            CoreTypes::STORE: begin
                idExNext.memWrEnable = 1'b1;
                idExNext.immediate   = {{20{inst[31]}}, inst[31:25], inst[11:7]}; // S-type
                o_srcRegs.rs2Used    = 1'b1;
            end
            default: begin
                known             = 1'b0;         // Outside the subset
                o_srcRegs.rs1Used = 1'b0;
            end
        endcase
        idExNext.isValid     = i_isValid && known;
        idExNext.regWrEnable = idExNext.regWrEnable && idExNext.isValid;
        idExNext.memRdEnable = idExNext.memRdEnable && idExNext.isValid;
        idExNext.memWrEnable = idExNext.memWrEnable && idExNext.isValid;
        idExNext.dataA       = forward(o_srcRegs.rs1, i_rdDataA);
        idExNext.dataB       = forward(o_srcRegs.rs2, i_rdDataB);
    end

    // ------------------------------
    // ID/EX register
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset || i_stallCtrl.idExFlush) begin    // Bubble
            o_idEx.isValid     <= 1'b0;
            o_idEx.regWrEnable <= 1'b0;
            o_idEx.memRdEnable <= 1'b0;
            o_idEx.memWrEnable <= 1'b0;
        end
        else if (!i_stallCtrl.idExStall)
            o_idEx <= idExNext;
    end

endmodule

// File: verilog/StageIF.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module StageIF (
    input  logic                    i_clock,      // Clock
    input  logic                    i_reset,      // Reset
    input  PipelineTypes::StallCtrl i_stallCtrl,  // Stall controls
    output CoreTypes::InstAddr      o_instAddr,   // Instruction bus address
    input  CoreTypes::Inst          i_inst,       // Word at o_instAddr
    output CoreTypes::InstAddr      o_pc,         // IF/ID address
    output CoreTypes::Inst          o_inst,       // IF/ID instruction
    output logic                    o_isValid);   // IF/ID valid

    CoreTypes::InstAddr pc;                       // Fetch address

    assign o_instAddr = pc;

    // ------------------------------
    // Program counter
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset)
            pc <= `RV_RESET_PC;
        else if (!i_stallCtrl.ifIdStall)
            pc <= pc + 32'd4;                     // No branches, always sequential
    end

    // ------------------------------
    // IF/ID register
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset)
            o_isValid <= 1'b0;
        else if (!i_stallCtrl.ifIdStall) begin
            o_isValid <= 1'b1;
            o_pc      <= pc;
            o_inst    <= i_inst;
        end
    end

endmodule

// File: verilog/StageMEM.sv
`timescale 1ns/1ps

module StageMEM (
    input  logic                     i_clock,       // Clock
    input  logic                     i_reset,       // Reset
    input  PipelineTypes::StallCtrl  i_stallCtrl,   // Stall controls
    input  PipelineTypes::ExMemReg   i_exMem,       // EX/MEM register
    output PipelineTypes::DataBusReq o_dataReq,     // Data bus request
    input  CoreTypes::Data           i_dataRdData,  // Load data
    input  logic                     i_dataBusy,    // Bus back-pressure
    output logic                     o_busyHazard,  // Pending and busy
    output CoreTypes::Data           o_wrData,      // Write-back value, also forwarded
    output PipelineTypes::MemWbReg   o_memWb);      // MEM/WB register

    logic pending;                                  // Request on the bus

    // ------------------------------
    // Data bus
    // ------------------------------

    assign o_dataReq.addr   = i_exMem.result;
    assign o_dataReq.wrData = i_exMem.storeData;
    assign o_dataReq.rd     = i_exMem.isValid && i_exMem.memRdEnable;
    assign o_dataReq.wr     = i_exMem.isValid && i_exMem.memWrEnable;

    assign pending      = o_dataReq.rd || o_dataReq.wr;
    assign o_busyHazard = pending && i_dataBusy;   // Stable request while high

    assign o_wrData = i_exMem.memRdEnable ? i_dataRdData : i_exMem.result;

    // ------------------------------
    // MEM/WB register
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset || i_stallCtrl.memWbFlush) begin
            o_memWb.isValid     <= 1'b0;
            o_memWb.regWrEnable <= 1'b0;
        end
        else begin
            o_memWb.isValid     <= i_exMem.isValid;
            o_memWb.regWrAddr   <= i_exMem.regWrAddr;
            o_memWb.regWrEnable <= i_exMem.regWrEnable;
            o_memWb.regWrData   <= o_wrData;
        end
    end

endmodule

// File: verilog/StallController.sv
`timescale 1ns/1ps

module StallController (
    input  PipelineTypes::SrcRegs   i_srcRegs,     // Sources of the ID instruction
    input  PipelineTypes::IdExReg   i_idEx,        // Instruction in EX
    input  logic                    i_busyHazard,  // Data bus busy
    output PipelineTypes::StallCtrl o_stallCtrl);  // Stage controls

    logic loadInEx;                                 // EX holds a load with a destination
    logic hitA;
    logic hitB;
    logic loadUse;

    // ------------------------------
    // Load-use detection
    // ------------------------------

    assign loadInEx = i_idEx.isValid && i_idEx.memRdEnable && i_idEx.regWrEnable &&
                      (i_idEx.regWrAddr != '0);
    assign hitA     = i_srcRegs.rs1Used && (i_srcRegs.rs1 == i_idEx.regWrAddr);
    assign hitB     = i_srcRegs.rs2Used && (i_srcRegs.rs2 == i_idEx.regWrAddr);
    assign loadUse  = loadInEx && (hitA || hitB);

    // ------------------------------
    // Combined controls
    // ------------------------------

    // Busy freezes IF..MEM and wins over the load-use bubble
    assign o_stallCtrl.ifIdStall  = loadUse || i_busyHazard;
    assign o_stallCtrl.idExStall  = i_busyHazard;
    assign o_stallCtrl.idExFlush  = loadUse && !i_busyHazard;
    assign o_stallCtrl.exMemStall = i_busyHazard;
    assign o_stallCtrl.memWbFlush = i_busyHazard;   // MEM result not ready yet

endmodule

// File: verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ------------------------------
// Core sizing
// ------------------------------

`define RV_XLEN      32                 // Data and address width
`define RV_REG_COUNT 32                 // Base integer registers

// ------------------------------
// Reset and filler values
// ------------------------------

`define RV_RESET_PC  32'h0000_0000      // First fetch address
`define RV_NOP       32'h0000_0013      // ADDI x0,x0,0

`endif
